// File: mmult_dot_cfg.svh
// Build-time sizes; FIFO depth must be a power of two of at least 2, vector length at least 1
`ifndef MMULT_DOT_CFG_SVH
`define MMULT_DOT_CFG_SVH

// Number of A/B operand pairs that are summed into one result
// A result is emitted after exactly this many pairs have been consumed
`define MMULT_DOT_LEN 4

// Entries in each operand FIFO
// The FIFO pointers wrap by overflow, so this must stay a power of two
`define MMULT_DOT_FIFO_DEPTH 4

// Width of the result counter reported by the flag block
// The counter wraps silently once it reaches its top value
`define MMULT_DOT_CNT_W 16

`endif

// File: mmult_dot_pkg.sv
// Shared scalar types only; the counter width follows MMULT_DOT_CNT_W from the config header
`include "mmult_dot_cfg.svh"

package mmult_dot_pkg;

  // One operand word as it arrives on stream A or stream B
  // Treated as a two's complement value by the engine
  typedef logic signed [15:0] operand_t;

  // Accumulator and result word
  // A 16x16 signed product fits exactly, so sums of several products wrap here
  typedef logic signed [31:0] acc_t;

  // Unsigned count of result handshakes since the last start
  typedef logic [`MMULT_DOT_CNT_W-1:0] cnt_t;

endpackage

// File: operand_fifo.sv
// Synchronous valid/ready FIFO with no bypass, so a word needs one cycle to reach the head
`timescale 1ns/100ps
`include "mmult_dot_cfg.svh"

module operand_fifo import mmult_dot_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  input  operand_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output operand_t out_data_o,
  input  logic     out_ready_i
);

  localparam int unsigned DEPTH = `MMULT_DOT_FIFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  // One extra code is needed to tell full apart from empty
  localparam int unsigned OCC_W = $clog2(DEPTH + 1);
  localparam logic [OCC_W-1:0] FULL = OCC_W'(DEPTH);

  operand_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [OCC_W-1:0] occ_q;

  logic push;
  logic pop;

  // Ready and valid come straight from the occupancy register
  // Neither depends on the far side of the FIFO, so no combinational loop can form
  assign in_ready_o  = (occ_q != FULL);
  assign out_valid_o = (occ_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // Storage array is written on every accepted word
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  // Pointers wrap by overflow since the depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Occupancy tracks push and pop together
  // A push and a pop in the same cycle leave the count unchanged
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      case ({push, pop})
        2'b10:   occ_q <= occ_q + 1'b1;
        2'b01:   occ_q <= occ_q - 1'b1;
        default: occ_q <= occ_q;
      endcase
    end
  end

endmodule

// File: dot_engine.sv
// Signed MAC over MMULT_DOT_LEN pairs; sums wrap at 32 bits and are never saturated
`timescale 1ns/100ps
`include "mmult_dot_cfg.svh"

module dot_engine import mmult_dot_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     a_valid_i,
  input  operand_t a_data_i,
  output logic     a_ready_o,
  input  logic     b_valid_i,
  input  operand_t b_data_i,
  output logic     b_ready_o,
  output logic     res_valid_o,
  output acc_t     res_data_o,
  input  logic     res_ready_i
);

  localparam int unsigned LEN = `MMULT_DOT_LEN;
  // A single pair per vector still needs a one-bit counter
  localparam int unsigned PAIR_W = (LEN > 1) ? $clog2(LEN) : 1;
  localparam logic [PAIR_W-1:0] LAST_PAIR = PAIR_W'(LEN - 1);

  logic [PAIR_W-1:0] pair_cnt_q;
  acc_t              acc_q;
  logic              res_valid_q;
  acc_t              res_data_q;

  logic last_pair;
  logic can_take;
  logic pair_fire;
  acc_t product;
  acc_t sum;

  // The current pair closes a vector when the counter sits at its last value
  assign last_pair = (pair_cnt_q == LAST_PAIR);

  // Every pair but the last goes straight into the accumulator
  // The closing pair also needs the result buffer, which is free when it is empty
  // or when its current word leaves in this same cycle
  assign can_take = !last_pair || !res_valid_q || res_ready_i;

  // Both heads are popped together, never one alone
  assign pair_fire = a_valid_i && b_valid_i && can_take;

  // Each ready waits for the partner stream so the two FIFOs stay in step
  assign a_ready_o = b_valid_i && can_take;
  assign b_ready_o = a_valid_i && can_take;

  // Operands are sign extended before the multiply
  // The 16x16 product fits in 32 bits, only the running sum can wrap
  assign product = acc_t'(a_data_i) * acc_t'(b_data_i);
  assign sum     = acc_q + product;

  // Pair counter and accumulator
  // On the closing pair the accumulator restarts from zero for the next vector
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pair_cnt_q <= '0;
      acc_q      <= '0;
    end else if (pair_fire) begin
      if (last_pair) begin
        pair_cnt_q <= '0;
        acc_q      <= '0;
      end else begin
        pair_cnt_q <= pair_cnt_q + 1'b1;
        acc_q      <= sum;
      end
    end
  end

  // Result buffer valid bit
  // A new result wins over a handshake in the same cycle, so nothing is dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else if (pair_fire && last_pair) begin
      res_valid_q <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  // Result word
  // It only changes when a vector closes, so it stays put while the consumer stalls
  always_ff @(posedge clk_i) begin
    if (pair_fire && last_pair) begin
      res_data_q <= sum;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_data_o  = res_data_q;

endmodule

// File: kernel_flags.sv
// Status flags follow the kernel adapter handshake rules; start_i is sampled every cycle
`timescale 1ns/100ps

module kernel_flags import mmult_dot_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic a_fire_i,
  input  logic b_fire_i,
  input  logic res_fire_i,
  output logic done_o,
  output logic idle_o,
  output logic ready_o,
  output cnt_t cnt_out_o
);

  logic done_q;
  logic idle_q;
  logic seen_a_q;
  logic seen_b_q;
  cnt_t cnt_out_q;

  // Done pulse
  // One cycle high after every result handshake, back to back results give a
  // continuous high level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else begin
      done_q <= res_fire_i;
    end
  end

  // Idle state
  // Start drops it in the next cycle and keeps it low while start is held
  // Without start, the cycle after a done pulse raises it again
  // It is low out of reset, the host is expected to issue a start first
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idle_q <= 1'b0;
    end else if (start_i) begin
      idle_q <= 1'b0;
    end else if (done_q) begin
      idle_q <= 1'b1;
    end
  end

  // Sticky input flags
  // Each one records that its stream has delivered at least one word since the
  // last start, start takes priority over a handshake in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_a_q <= 1'b0;
      seen_b_q <= 1'b0;
    end else if (start_i) begin
      seen_a_q <= 1'b0;
      seen_b_q <= 1'b0;
    end else begin
      if (a_fire_i) begin
        seen_a_q <= 1'b1;
      end
      if (b_fire_i) begin
        seen_b_q <= 1'b1;
      end
    end
  end

  // Output counter
  // Counts result handshakes, so it moves on the same edge that raises done
  // It wraps at the top of cnt_t
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_out_q <= '0;
    end else if (start_i) begin
      cnt_out_q <= '0;
    end else if (res_fire_i) begin
      cnt_out_q <= cnt_out_q + 1'b1;
    end
  end

  assign done_o    = done_q;
  assign idle_o    = idle_q;
  // Ready needs both operand streams to have started flowing
  assign ready_o   = seen_a_q & seen_b_q;
  assign cnt_out_o = cnt_out_q;

endmodule

// File: mmult_dot_top.sv
// Dot-product accelerator top; min latency 2 cycles from last operand, start_i is a plain level
`timescale 1ns/100ps

module mmult_dot_top import mmult_dot_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,
  input  logic     a_valid_i,
  input  operand_t a_data_i,
  output logic     a_ready_o,
  input  logic     b_valid_i,
  input  operand_t b_data_i,
  output logic     b_ready_o,
  output logic     res_valid_o,
  output acc_t     res_data_o,
  input  logic     res_ready_i,
  output logic     done_o,
  output logic     idle_o,
  output logic     ready_o,
  output cnt_t     cnt_out_o
);

  // FIFO heads toward the engine
  logic     head_a_valid;
  operand_t head_a_data;
  logic     head_a_ready;
  logic     head_b_valid;
  operand_t head_b_data;
  logic     head_b_ready;

  // Handshakes seen by the flag block
  logic a_fire;
  logic b_fire;
  logic res_fire;

  // Stream A buffer
  operand_fifo u_fifo_a (
    .clk_i       ( clk_i        ),
    .rst_ni      ( rst_ni       ),
    .in_valid_i  ( a_valid_i    ),
    .in_data_i   ( a_data_i     ),
    .in_ready_o  ( a_ready_o    ),
    .out_valid_o ( head_a_valid ),
    .out_data_o  ( head_a_data  ),
    .out_ready_i ( head_a_ready )
  );

  // Stream B buffer
  operand_fifo u_fifo_b (
    .clk_i       ( clk_i        ),
    .rst_ni      ( rst_ni       ),
    .in_valid_i  ( b_valid_i    ),
    .in_data_i   ( b_data_i     ),
    .in_ready_o  ( b_ready_o    ),
    .out_valid_o ( head_b_valid ),
    .out_data_o  ( head_b_data  ),
    .out_ready_i ( head_b_ready )
  );

  dot_engine u_engine (
    .clk_i       ( clk_i        ),
    .rst_ni      ( rst_ni       ),
    .a_valid_i   ( head_a_valid ),
    .a_data_i    ( head_a_data  ),
    .a_ready_o   ( head_a_ready ),
    .b_valid_i   ( head_b_valid ),
    .b_data_i    ( head_b_data  ),
    .b_ready_o   ( head_b_ready ),
    .res_valid_o ( res_valid_o  ),
    .res_data_o  ( res_data_o   ),
    .res_ready_i ( res_ready_i  )
  );

  // Input handshakes are taken at the outer ports, before the FIFOs
  assign a_fire   = a_valid_i & a_ready_o;
  assign b_fire   = b_valid_i & b_ready_o;
  assign res_fire = res_valid_o & res_ready_i;

  kernel_flags u_flags (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .start_i    ( start_i   ),
    .a_fire_i   ( a_fire    ),
    .b_fire_i   ( b_fire    ),
    .res_fire_i ( res_fire  ),
    .done_o     ( done_o    ),
    .idle_o     ( idle_o    ),
    .ready_o    ( ready_o   ),
    .cnt_out_o  ( cnt_out_o )
  );

endmodule

// File: tb_mmult_dot.sv
// Uses the default sizes from the config header; stimulus is seeded random and every wait is bounded
`timescale 1ns/100ps
`include "mmult_dot_cfg.svh"

module tb_mmult_dot import mmult_dot_pkg::*; ();

  localparam int LEN        = `MMULT_DOT_LEN;
  localparam int FIFO_DEPTH = `MMULT_DOT_FIFO_DEPTH;
  localparam int WAIT_LIMIT = 4000;

  logic     clk_i;
  logic     rst_ni;
  logic     start_i;
  logic     a_valid_i;
  operand_t a_data_i;
  logic     a_ready_o;
  logic     b_valid_i;
  operand_t b_data_i;
  logic     b_ready_o;
  logic     res_valid_o;
  acc_t     res_data_o;
  logic     res_ready_i;
  logic     done_o;
  logic     idle_o;
  logic     ready_o;
  cnt_t     cnt_out_o;

  // Reference model of the data path
  // Accepted words wait here until a partner word arrives on the other stream
  operand_t a_seen_q [$];
  operand_t b_seen_q [$];
  acc_t     exp_q [$];
  acc_t     model_acc;
  int       model_pairs;
  logic     exp_valid;
  acc_t     exp_data;
  int       res_total;

  // Words accepted on each input stream since reset
  int       a_total;
  int       b_total;

  // Reference model of the flag block
  logic done_exp;
  logic idle_exp;
  logic seen_a_exp;
  logic seen_b_exp;
  cnt_t cnt_exp;

  // A result that waited at the last edge, with its word at that time
  logic held_q;
  acc_t held_data_q;

  int   err_cnt;
  int   test_cnt;
  int   test_fail_cnt;
  logic timed_out;

  mmult_dot_top uut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .start_i     ( start_i     ),
    .a_valid_i   ( a_valid_i   ),
    .a_data_i    ( a_data_i    ),
    .a_ready_o   ( a_ready_o   ),
    .b_valid_i   ( b_valid_i   ),
    .b_data_i    ( b_data_i    ),
    .b_ready_o   ( b_ready_o   ),
    .res_valid_o ( res_valid_o ),
    .res_data_o  ( res_data_o  ),
    .res_ready_i ( res_ready_i ),
    .done_o      ( done_o      ),
    .idle_o      ( idle_o      ),
    .ready_o     ( ready_o     ),
    .cnt_out_o   ( cnt_out_o   )
  );

  // 8 ns clock period
  always #4 clk_i = ~clk_i;

  // Pairs the k-th A word with the k-th B word and sums LEN products
  // Products are formed at 64 bits and cut to 32, which gives the wrapping sum
  always @(posedge clk_i) begin : ref_model
    longint wide;
    if (!rst_ni) begin
      a_seen_q.delete();
      b_seen_q.delete();
      exp_q.delete();
      model_acc   = '0;
      model_pairs = 0;
      exp_valid   <= 1'b0;
      exp_data    <= '0;
      res_total   <= 0;
      a_total     <= 0;
      b_total     <= 0;
    end else begin
      if (res_valid_o && res_ready_i) begin
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end
        res_total <= res_total + 1;
      end
      if (a_valid_i && a_ready_o) begin
        a_seen_q.push_back(a_data_i);
        a_total <= a_total + 1;
      end
      if (b_valid_i && b_ready_o) begin
        b_seen_q.push_back(b_data_i);
        b_total <= b_total + 1;
      end
      while (a_seen_q.size() > 0 && b_seen_q.size() > 0) begin
        wide        = longint'(a_seen_q.pop_front()) * longint'(b_seen_q.pop_front());
        model_acc   = model_acc + wide[31:0];
        model_pairs = model_pairs + 1;
        if (model_pairs == LEN) begin
          exp_q.push_back(model_acc);
          model_acc   = '0;
          model_pairs = 0;
        end
      end
      exp_valid <= (exp_q.size() > 0);
      exp_data  <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end
  end

  // Flag model where start clears, handshakes set and idle rises after a done without start
  always @(posedge clk_i) begin : flag_model
    if (!rst_ni) begin
      done_exp    <= 1'b0;
      idle_exp    <= 1'b0;
      seen_a_exp  <= 1'b0;
      seen_b_exp  <= 1'b0;
      cnt_exp     <= '0;
      held_q      <= 1'b0;
      held_data_q <= '0;
    end else begin
      done_exp    <= res_valid_o && res_ready_i;
      held_q      <= res_valid_o && !res_ready_i;
      held_data_q <= res_data_o;
      if (start_i) begin
        idle_exp   <= 1'b0;
        seen_a_exp <= 1'b0;
        seen_b_exp <= 1'b0;
        cnt_exp    <= '0;
      end else begin
        if (done_exp) begin
          idle_exp <= 1'b1;
        end
        if (a_valid_i && a_ready_o) begin
          seen_a_exp <= 1'b1;
        end
        if (b_valid_i && b_ready_o) begin
          seen_b_exp <= 1'b1;
        end
        if (res_valid_o && res_ready_i) begin
          cnt_exp <= cnt_exp + 1'b1;
        end
      end
    end
  end

  task automatic log_error(input string what);
    err_cnt++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  task automatic count_mismatch(input string name, input longint exp_val, input longint act_val);
    err_cnt++;
    $display("mismatch at %0t ns: %s expected %0d got %0d", $time, name, exp_val, act_val);
  endtask

  // All checks sample on the falling edge, half a cycle away from any change
  reset_check: assert property (@(negedge clk_i) !rst_ni |-> !res_valid_o)
    else count_mismatch("res_valid_o", 0, res_valid_o);
  spurious_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
      res_valid_o |-> exp_valid)
    else log_error("res_valid_o is high while no result is expected");
  result_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
      res_valid_o && exp_valid |-> res_data_o == exp_data)
    else count_mismatch("res_data_o", exp_data, res_data_o);
  hold_valid_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
      held_q |-> res_valid_o)
    else log_error("res_valid_o dropped before the result was taken");
  hold_data_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
      held_q |-> res_data_o == held_data_q)
    else count_mismatch("res_data_o", held_data_q, res_data_o);
  done_check: assert property (@(negedge clk_i) done_o == done_exp)
    else count_mismatch("done_o", done_exp, done_o);
  cnt_check: assert property (@(negedge clk_i) cnt_out_o == cnt_exp)
    else count_mismatch("cnt_out_o", cnt_exp, cnt_out_o);
  ready_check: assert property (@(negedge clk_i) ready_o == (seen_a_exp && seen_b_exp))
    else count_mismatch("ready_o", seen_a_exp && seen_b_exp, ready_o);
  idle_check: assert property (@(negedge clk_i) idle_o == idle_exp)
    else count_mismatch("idle_o", idle_exp, idle_o);

  // An input FIFO cannot be full while fewer than FIFO_DEPTH of its accepted words
  // are still outside a taken result
  a_ready_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
      (a_total - LEN * res_total < FIFO_DEPTH) |-> a_ready_o)
    else count_mismatch("a_ready_o", 1, a_ready_o);
  b_ready_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
      (b_total - LEN * res_total < FIFO_DEPTH) |-> b_ready_o)
    else count_mismatch("b_ready_o", 1, b_ready_o);

  task automatic close_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt != err_before) begin
      test_fail_cnt++;
      $display("test %0d %s: failed with %0d errors", test_cnt, name, err_cnt - err_before);
    end else begin
      $display("test %0d %s: passed", test_cnt, name);
    end
  endtask

  // Extreme mode uses only the two largest magnitudes so that sums wrap
  function automatic operand_t pick_operand(input bit extreme);
    operand_t val;
    if (extreme) begin
      val = ($urandom_range(1) == 0) ? 16'sh8000 : 16'sh7fff;
    end else begin
      val = operand_t'($urandom);
    end
    return val;
  endfunction

  task automatic pulse_start();
    @(posedge clk_i);
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  // Drives both streams as independent senders and samples ready at the falling edge
  // B can be held back for b_delay cycles so that A runs ahead
  task automatic stream_operands(input int n_vec, input int gap_pct, input int b_delay,
                                 input bit extreme);
    int   a_left;
    int   b_left;
    int   cycles;
    logic a_on;
    logic b_on;
    logic a_took;
    logic b_took;
    a_left = n_vec * LEN;
    b_left = n_vec * LEN;
    a_on   = 1'b0;
    b_on   = 1'b0;
    cycles = 0;
    while (!timed_out && (a_left > 0 || b_left > 0 || a_on || b_on)) begin
      @(negedge clk_i);
      a_took = a_on && a_ready_o;
      b_took = b_on && b_ready_o;
      @(posedge clk_i);
      cycles++;
      if (a_took) begin
        a_on = 1'b0;
      end
      if (!a_on && a_left > 0 && $urandom_range(99) >= gap_pct) begin
        a_on = 1'b1;
        a_left--;
        a_data_i <= pick_operand(extreme);
      end
      if (b_took) begin
        b_on = 1'b0;
      end
      if (!b_on && b_left > 0 && cycles > b_delay && $urandom_range(99) >= gap_pct) begin
        b_on = 1'b1;
        b_left--;
        b_data_i <= pick_operand(extreme);
      end
      a_valid_i <= a_on;
      b_valid_i <= b_on;
      if (cycles >= WAIT_LIMIT) begin
        log_error("operand streams were not accepted in time");
        timed_out = 1'b1;
      end
    end
  endtask

  // Random back-pressure until the wanted number of results has been taken
  task automatic drain_results(input int target, input int ready_pct);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!timed_out && res_total < target) begin
      @(posedge clk_i);
      res_ready_i <= ($urandom_range(99) < ready_pct);
      cycles++;
      if (cycles >= WAIT_LIMIT) begin
        log_error("results did not arrive in time");
        timed_out = 1'b1;
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    res_ready_i <= 1'b0;
  endtask

  task automatic run_vectors(input int n_vec, input int gap_pct, input int b_delay,
                             input int ready_pct, input bit extreme);
    int target;
    @(negedge clk_i);
    target = res_total + n_vec;
    fork
      stream_operands(n_vec, gap_pct, b_delay, extreme);
      drain_results(target, ready_pct);
    join
    repeat (4) @(negedge clk_i);
    leftover_check: assert (timed_out || !exp_valid)
      else log_error("expected results were never delivered");
  endtask

  initial begin : main_seq
    int seed_val;
    int base_err;
    seed_val      = $urandom(22759);
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    start_i       = 1'b0;
    a_valid_i     = 1'b0;
    a_data_i      = '0;
    b_valid_i     = 1'b0;
    b_data_i      = '0;
    res_ready_i   = 1'b0;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    timed_out     = 1'b0;

    // Reset for 16 cycles, then watch the outputs settle
    base_err = err_cnt;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (4) @(negedge clk_i);
    close_test("reset values", base_err);

    base_err = err_cnt;
    pulse_start();
    run_vectors(4, 40, 0, 100, 1'b0);
    close_test("random input gaps", base_err);

    // A slow consumer lets the FIFOs fill so that the input ready lines drop
    base_err = err_cnt;
    run_vectors(6, 0, 0, 30, 1'b0);
    close_test("result back-pressure", base_err);

    base_err = err_cnt;
    run_vectors(3, 10, 0, 70, 1'b1);
    close_test("wrapping sums", base_err);

    // B starts late, so ready_o waits for its first word
    base_err = err_cnt;
    pulse_start();
    run_vectors(2, 20, 12, 60, 1'b0);
    close_test("restart and ready", base_err);

    base_err = err_cnt;
    pulse_start();
    repeat (3) @(negedge clk_i);
    run_vectors(1, 0, 0, 100, 1'b0);
    repeat (4) @(negedge clk_i);
    close_test("idle after done", base_err);

    $display("tests run: %0d, tests failed: %0d, errors: %0d", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: mmult_dot.f
+incdir+.
mmult_dot_pkg.sv
operand_fifo.sv
dot_engine.sv
kernel_flags.sv
mmult_dot_top.sv
tb_mmult_dot.sv

// File: Makefile
# Verilator simulation of the dot-product accelerator

SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_mmult_dot
FILELIST := mmult_dot.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
